// File: flist.f
+incdir+testbench
rtl/regfile_pkg.sv
rtl/gpr_write_merge.sv
rtl/gpr_bank.sv
rtl/operand_read_port.sv
rtl/register_file.sv
testbench/tb_register_file.sv

// File: Bender.yml
package:
  name: register_file

sources:
  - files:
      - rtl/regfile_pkg.sv
      - rtl/gpr_write_merge.sv
      - rtl/gpr_bank.sv
      - rtl/operand_read_port.sv
      - rtl/register_file.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_register_file.sv

// File: testbench/tb_gpr_model.svh
/*
 * Shadow model of the GPR file, included inside the testbench module.
 * 8-bit numbers 4..7 name byte 1 of registers 0..3 for reads and writes.
 * Size code 3 writes are dropped and size code 3 reads give zero.
 */

`ifndef TB_GPR_MODEL_SVH
`define TB_GPR_MODEL_SVH

logic [31:0] shadow_regs [0:7];

task automatic clear_shadow();
    for (int i = 0; i < 8; i++) begin
        shadow_regs[i] = 32'h0;
    end
endtask

task automatic apply_shadow_write(input regfile_pkg::reg_idx_t sel,
                                  input regfile_pkg::op_size_t size,
                                  input logic [31:0] data);
    case (size)
        regfile_pkg::size_32: begin
            shadow_regs[sel] = data;
        end
        regfile_pkg::size_16: begin
            shadow_regs[sel][15:0] = data[15:0];
        end
        regfile_pkg::size_8: begin
            // ah, ch, dh, bh
            if (sel[2]) begin
                shadow_regs[sel[1:0]][15:8] = data[7:0];
            end else begin
                shadow_regs[sel][7:0] = data[7:0];
            end
        end
        default: begin
        end
    endcase
endtask

function automatic logic [31:0] expected_read(input regfile_pkg::reg_idx_t sel,
                                              input regfile_pkg::op_size_t size);
    case (size)
        regfile_pkg::size_32: return shadow_regs[sel];
        regfile_pkg::size_16: return {16'h0, shadow_regs[sel][15:0]};
        regfile_pkg::size_8: begin
            if (sel[2]) begin
                return {24'h0, shadow_regs[sel[1:0]][15:8]};
            end
            return {24'h0, shadow_regs[sel][7:0]};
        end
        default: return 32'h0;
    endcase
endfunction

`endif

// File: testbench/tb_register_file.sv
/*
 * Self-checking testbench for the GPR file.
 * All four read ports are compared with a shadow model at every falling
 * edge. Random stimulus comes from an LCG with a fixed seed.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_register_file;

    localparam int clk_half_period = 50;
    localparam int reset_cycles    = 3;
    localparam int random_cycles   = 2000;
    localparam int clear_timeout   = 10;

    logic                  clk;
    logic                  reset;
    regfile_pkg::op_size_t register_size;
    regfile_pkg::reg_idx_t op_1;
    regfile_pkg::reg_idx_t op_2;
    regfile_pkg::reg_idx_t sib_base_reg;
    regfile_pkg::reg_idx_t sib_index_reg;
    regfile_pkg::reg_idx_t writeback_reg;
    logic                  writeback_en;
    regfile_pkg::op_size_t writeback_size;
    logic [31:0]           writeback_data;
    logic [31:0]           op_1_value;
    logic [31:0]           op_2_value;
    logic [31:0]           sib_base_value;
    logic [31:0]           sib_index_value;

    int          error_count;
    int          timeout_count;
    logic        checks_on;
    logic [31:0] lcg_state;

    `include "tb_gpr_model.svh"

    register_file u_register_file (
        .clk             (clk),
        .reset           (reset),
        .register_size   (register_size),
        .op_1            (op_1),
        .op_1_value      (op_1_value),
        .op_2            (op_2),
        .op_2_value      (op_2_value),
        .sib_base_reg    (sib_base_reg),
        .sib_base_value  (sib_base_value),
        .sib_index_reg   (sib_index_reg),
        .sib_index_value (sib_index_value),
        .writeback_reg   (writeback_reg),
        .writeback_en    (writeback_en),
        .writeback_size  (writeback_size),
        .writeback_data  (writeback_data)
    );

    always #clk_half_period clk = ~clk;

    // ----------------------------------------
    // shadow model and checks
    // ----------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            clear_shadow();
        end else if (writeback_en) begin
            apply_shadow_write(writeback_reg, writeback_size, writeback_data);
        end
    end

    task automatic check_port(input string port_name, input regfile_pkg::reg_idx_t sel,
                              input logic [31:0] got, input logic [31:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED at time %0t: %s for reg %0d read 0x%08h, expected 0x%08h",
                     $time, port_name, sel, got, expected);
            error_count++;
        end
    endtask

    // a write in this cycle is not yet in the model, so old values are expected
    always @(negedge clk) begin
        if (checks_on) begin
            check_port("op_1_value", op_1, op_1_value, expected_read(op_1, register_size));
            check_port("op_2_value", op_2, op_2_value, expected_read(op_2, register_size));
            check_port("sib_base_value", sib_base_reg, sib_base_value,
                       shadow_regs[sib_base_reg]);
            check_port("sib_index_value", sib_index_reg, sib_index_value,
                       shadow_regs[sib_index_reg]);
        end
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic write_and_read(input logic en, input regfile_pkg::reg_idx_t wr_sel,
                                  input regfile_pkg::op_size_t wr_size,
                                  input logic [31:0] data,
                                  input regfile_pkg::op_size_t rd_size,
                                  input regfile_pkg::reg_idx_t rd_sel);
        @(posedge clk);
        #1;
        writeback_en   = en;
        writeback_reg  = wr_sel;
        writeback_size = wr_size;
        writeback_data = data;
        register_size  = rd_size;
        op_1           = rd_sel;
        op_2           = ~rd_sel;
        sib_base_reg   = rd_sel;
        sib_index_reg  = rd_sel + 3'd1;
    endtask

    task automatic sweep_reads(input regfile_pkg::op_size_t rd_size);
        for (int r = 0; r < 8; r++) begin
            write_and_read(1'b0, 3'd0, regfile_pkg::size_32, 32'h0, rd_size, r[2:0]);
        end
    endtask

    task automatic wait_bank_cleared(output logic cleared);
        cleared = 1'b0;
        for (int cycle = 0; cycle < clear_timeout && !cleared; cycle++) begin
            @(negedge clk);
            if (sib_base_value === 32'h0 && sib_index_value === 32'h0) begin
                cleared = 1'b1;
            end
        end
        if (!cleared) begin
            $display("TIMEOUT: register bank did not read zero %0d cycles after reset",
                     clear_timeout);
            timeout_count++;
        end
    endtask

    task automatic run_random_cycles();
        logic [31:0] ctrl;
        for (int n = 0; n < random_cycles; n++) begin
            ctrl = next_random();
            write_and_read(ctrl[31] | ctrl[30], ctrl[29:27], ctrl[26:25], next_random(),
                           ctrl[24:23], ctrl[22:20]);
            // decouple the other ports from op_1
            op_2          = ctrl[19:17];
            sib_base_reg  = ctrl[16:14];
            sib_index_reg = ctrl[13:11];
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic cleared;
        clk           = 1'b0;
        reset         = 1'b1;
        register_size = regfile_pkg::size_32;
        op_1          = 3'd0;
        op_2          = 3'd0;
        sib_base_reg  = 3'd0;
        sib_index_reg = 3'd7;
        writeback_reg = 3'd0;
        writeback_en  = 1'b0;
        writeback_size = regfile_pkg::size_32;
        writeback_data = 32'h0;
        error_count   = 0;
        timeout_count = 0;
        checks_on     = 1'b0;
        lcg_state     = 32'd10;

        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_bank_cleared(cleared);

        if (cleared) begin
            checks_on = 1'b1;
            // all zero after reset, at every size
            for (int s = 0; s < 4; s++) begin
                sweep_reads(s[1:0]);
            end
            // full writes, read back in the same cycle and after
            for (int r = 0; r < 8; r++) begin
                write_and_read(1'b1, r[2:0], regfile_pkg::size_32, next_random(),
                               regfile_pkg::size_32, r[2:0]);
            end
            sweep_reads(regfile_pkg::size_32);
            // 16-bit writes keep the upper half
            for (int r = 0; r < 8; r++) begin
                write_and_read(1'b1, r[2:0], regfile_pkg::size_16, next_random(),
                               regfile_pkg::size_16, r[2:0]);
            end
            sweep_reads(regfile_pkg::size_16);
            sweep_reads(regfile_pkg::size_32);
            // 8-bit writes, low bytes then high bytes
            for (int r = 0; r < 8; r++) begin
                write_and_read(1'b1, r[2:0], regfile_pkg::size_8, next_random(),
                               regfile_pkg::size_8, r[2:0]);
            end
            sweep_reads(regfile_pkg::size_8);
            sweep_reads(regfile_pkg::size_32);
            // disabled writes and size code 3 writes change nothing
            for (int r = 0; r < 8; r++) begin
                write_and_read(1'b0, r[2:0], regfile_pkg::size_32, next_random(),
                               2'd3, r[2:0]);
                write_and_read(1'b1, r[2:0], 2'd3, next_random(), 2'd3, r[2:0]);
            end
            sweep_reads(regfile_pkg::size_32);
            run_random_cycles();
            sweep_reads(regfile_pkg::size_32);
            // the last falling edge check runs before this edge
            @(posedge clk);
        end

        $display("errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
/*
 * GPR file top: eight 32-bit registers, one sized writeback port,
 * two sized operand reads sharing register_size, two SIB address reads.
 * Reads are combinational and show the old value during a write cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic                            reset,

    // operand size shared by both operand ports
    input  regfile_pkg::op_size_t           register_size,

    input  regfile_pkg::reg_idx_t           op_1,
    output logic [regfile_pkg::data_w-1:0]  op_1_value,

    input  regfile_pkg::reg_idx_t           op_2,
    output logic [regfile_pkg::data_w-1:0]  op_2_value,

    input  regfile_pkg::reg_idx_t           sib_base_reg,
    output logic [regfile_pkg::data_w-1:0]  sib_base_value,
    input  regfile_pkg::reg_idx_t           sib_index_reg,
    output logic [regfile_pkg::data_w-1:0]  sib_index_value,

    input  regfile_pkg::reg_idx_t           writeback_reg,
    input  logic                            writeback_en,
    input  regfile_pkg::op_size_t           writeback_size,
    input  logic [regfile_pkg::data_w-1:0]  writeback_data
);

    // ----------------------------------------
    // internal connections
    // ----------------------------------------
    regfile_pkg::gpr_array_t           regs;
    logic [regfile_pkg::gpr_count-1:0] load_en;
    regfile_pkg::gpr_word_u            next_word;

    // ----------------------------------------
    // register storage and SIB reads
    // ----------------------------------------
    gpr_bank u_gpr_bank (
        .clk             (clk),
        .reset           (reset),
        .load_en         (load_en),
        .next_word       (next_word),
        .sib_base_reg    (sib_base_reg),
        .sib_index_reg   (sib_index_reg),
        .regs            (regs),
        .sib_base_value  (sib_base_value),
        .sib_index_value (sib_index_value)
    );

    // ----------------------------------------
    // writeback
    // ----------------------------------------
    gpr_write_merge u_gpr_write_merge (
        .writeback_reg  (writeback_reg),
        .writeback_size (writeback_size),
        .writeback_data (writeback_data),
        .writeback_en   (writeback_en),
        .regs           (regs),
        .load_en        (load_en),
        .next_word      (next_word)
    );

    // ----------------------------------------
    // operand reads
    // ----------------------------------------
    operand_read_port u_op1_port (
        .regs    (regs),
        .reg_sel (op_1),
        .size    (register_size),
        .value   (op_1_value)
    );

    operand_read_port u_op2_port (
        .regs    (regs),
        .reg_sel (op_2),
        .size    (register_size),
        .value   (op_2_value)
    );

endmodule

`default_nettype wire

// File: rtl/operand_read_port.sv
/*
 * One sized operand read port, combinational.
 * Result is zero-extended to 32 bits; size code 3 reads as zero.
 * For 8-bit reads, numbers 4..7 return byte 1 of registers 0..3.
 */

`timescale 1ns/1ps
`default_nettype none

module operand_read_port (
    input  regfile_pkg::gpr_array_t         regs,
    input  regfile_pkg::reg_idx_t           reg_sel,
    input  regfile_pkg::op_size_t           size,
    output logic [regfile_pkg::data_w-1:0]  value
);

    logic                   high_byte;
    regfile_pkg::reg_idx_t  phys_reg;
    regfile_pkg::gpr_word_u word;

    // ----------------------------------------
    // register select
    // ----------------------------------------
    // same high byte mapping as the writeback side
    always_comb begin
        high_byte = (size == regfile_pkg::size_8) &&
                    (reg_sel >= regfile_pkg::byte_reg_split);

        if (high_byte) begin
            phys_reg = reg_sel - regfile_pkg::byte_reg_split;
        end else begin
            phys_reg = reg_sel;
        end
    end

    assign word = regs[phys_reg];

    // ----------------------------------------
    // lane extract and zero extend
    // ----------------------------------------
    always_comb begin
        value = '0;

        case (size)
            regfile_pkg::size_32: begin
                value = word.dword;
            end
            regfile_pkg::size_16: begin
                value[regfile_pkg::data_w/2-1:0] = {word.lanes.high, word.lanes.low};
            end
            regfile_pkg::size_8: begin
                if (high_byte) begin
                    value[regfile_pkg::data_w/4-1:0] = word.lanes.high;
                end else begin
                    value[regfile_pkg::data_w/4-1:0] = word.lanes.low;
                end
            end
            default: begin
                // size 3 is unused and reads as zero
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/gpr_bank.sv
/*
 * The eight 32-bit general purpose registers.
 * Synchronous active high reset clears all of them to zero.
 * SIB base/index reads are full width and combinational, no write bypass.
 */

`timescale 1ns/1ps
`default_nettype none

module gpr_bank (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [regfile_pkg::gpr_count-1:0] load_en,
    input  regfile_pkg::gpr_word_u            next_word,
    input  regfile_pkg::reg_idx_t             sib_base_reg,
    input  regfile_pkg::reg_idx_t             sib_index_reg,
    output regfile_pkg::gpr_array_t           regs,
    output logic [regfile_pkg::data_w-1:0]    sib_base_value,
    output logic [regfile_pkg::data_w-1:0]    sib_index_value
);

    // ----------------------------------------
    // register storage
    // ----------------------------------------
    // at most one load_en bit is set and every register
    // shares the same merged word on its input
    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < regfile_pkg::gpr_count; i++) begin
                if (load_en[i]) begin
                    regs[i] <= next_word;
                end
            end
        end
    end

    // ----------------------------------------
    // SIB address reads
    // ----------------------------------------
    // base and index always use the whole dword
    // whatever the operand size
    regfile_pkg::gpr_word_u base_word;
    regfile_pkg::gpr_word_u index_word;

    assign base_word  = regs[sib_base_reg];
    assign index_word = regs[sib_index_reg];

    assign sib_base_value  = base_word.dword;
    assign sib_index_value = index_word.dword;

endmodule

`default_nettype wire

// File: rtl/gpr_write_merge.sv
/*
 * Writeback merge for the GPR file. Purely combinational.
 * Merges 32/16/8-bit data into the old value of the target register.
 * load_en is one-hot, and all zero when disabled or for size code 3.
 */

`timescale 1ns/1ps
`default_nettype none

module gpr_write_merge (
    input  regfile_pkg::reg_idx_t            writeback_reg,
    input  regfile_pkg::op_size_t            writeback_size,
    input  logic [regfile_pkg::data_w-1:0]   writeback_data,
    input  logic                             writeback_en,
    input  regfile_pkg::gpr_array_t          regs,
    output logic [regfile_pkg::gpr_count-1:0] load_en,
    output regfile_pkg::gpr_word_u           next_word
);

    // ----------------------------------------
    // target register and lane
    // ----------------------------------------
    logic                  high_byte;
    logic                  size_ok;
    logic                  write_ok;
    regfile_pkg::reg_idx_t phys_reg;

    // writeback data seen through the lane view
    regfile_pkg::gpr_word_u data_word;

    always_comb begin
        // ah..bh live in byte 1 of eax..ebx
        high_byte = (writeback_size == regfile_pkg::size_8) &&
                    (writeback_reg >= regfile_pkg::byte_reg_split);

        if (high_byte) begin
            phys_reg = writeback_reg - regfile_pkg::byte_reg_split;
        end else begin
            phys_reg = writeback_reg;
        end
    end

    assign data_word.dword = writeback_data;

    // ----------------------------------------
    // merge into the old value
    // ----------------------------------------
    always_comb begin
        next_word = regs[phys_reg];

        case (writeback_size)
            regfile_pkg::size_32: begin
                next_word.dword = data_word.dword;
            end
            regfile_pkg::size_16: begin
                // upper half kept
                next_word.lanes.high = data_word.lanes.high;
                next_word.lanes.low  = data_word.lanes.low;
            end
            regfile_pkg::size_8: begin
                // source byte is always data[7:0] and only the destination lane moves
                if (high_byte) begin
                    next_word.lanes.high = data_word.lanes.low;
                end else begin
                    next_word.lanes.low = data_word.lanes.low;
                end
            end
            default: begin
                // size 3 leaves the word as is and load_en low
            end
        endcase
    end

    // ----------------------------------------
    // one-hot load enables
    // ----------------------------------------
    assign size_ok = (writeback_size == regfile_pkg::size_32) ||
                     (writeback_size == regfile_pkg::size_16) ||
                     (writeback_size == regfile_pkg::size_8);

    assign write_ok = writeback_en && size_ok;

    always_comb begin
        for (int i = 0; i < regfile_pkg::gpr_count; i++) begin
            load_en[i] = write_ok && (phys_reg == i);
        end
    end

endmodule

`default_nettype wire

// File: rtl/regfile_pkg.sv
/*
 * Shared widths, size codes and register word types for the GPR file.
 * Size code 3 is unused: writes with it are dropped, reads return zero.
 * 8-bit register numbers 4..7 name the second byte of registers 0..3.
 */

`default_nettype none

package regfile_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int gpr_count = 8;
    localparam int data_w    = 32;
    localparam int reg_idx_w = 3;
    localparam int size_w    = 2;

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [size_w-1:0]    op_size_t;

    // ----------------------------------------
    // operand size codes
    // ----------------------------------------
    localparam op_size_t size_32 = 2'd0;
    localparam op_size_t size_16 = 2'd1;
    localparam op_size_t size_8  = 2'd2;

    // first 8-bit register number that maps onto a high byte (ah)
    localparam reg_idx_t byte_reg_split = 3'd4;

    // ----------------------------------------
    // register word, seen whole or by lane
    // ----------------------------------------
    typedef union packed {
        logic [data_w-1:0] dword;
        struct packed {
            logic [data_w/2-1:0] upper;
            // bits 15:8, the ah/ch/dh/bh byte
            logic [data_w/4-1:0] high;
            // bits 7:0, the al/cl/dl/bl byte
            logic [data_w/4-1:0] low;
        } lanes;
    } gpr_word_u;

    // all eight registers, eax in element 0 through edi in element 7
    typedef gpr_word_u [gpr_count-1:0] gpr_array_t;

endpackage

`default_nettype wire
